//--- hdl/addr_chan_if.sv
// Arbitrated address channel
// Carries the granted request, its ID already extended, and the winning port
`timescale 1ns/100ps
`default_nettype none

interface addr_chan_if
  import mux_cfg_pkg::*;
  import mux_chan_pkg::*;
();

  logic          valid;  // Request offered by the arbiter
  logic          ready;  // Accepted by the consumer
  dn_addr_chan_t chan;   // Downstream ID and address
  port_idx_t     port;   // Index of the granted upstream port

  // Arbiter side
  modport src (
    output valid,
    output chan,
    output port,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  chan,
    input  port,
    output ready
  );

endinterface

`default_nettype wire

//--- hdl/addr_rr_arbiter.sv
// Round-robin address arbiter
// Grants one upstream AW or AR request at a time, holds it until accepted,
// and extends the ID with the winner's port index
`timescale 1ns/100ps
`default_nettype none

module addr_rr_arbiter
  import mux_cfg_pkg::*;
  import mux_chan_pkg::*;
(
  input  wire logic                          clk_i,
  input  wire logic                          arst_n_i,
  input  wire logic          [NUM_PORTS-1:0] req_valid_i,
  input  wire up_addr_chan_t [NUM_PORTS-1:0] req_chan_i,
  output logic               [NUM_PORTS-1:0] req_ready_o,
  addr_chan_if.src                           grant
);

  logic      lock_q;   // Grant held while unacknowledged
  port_idx_t sel_q;    // Port held by the lock
  port_idx_t last_q;   // Most recent winner, round-robin pointer

  port_idx_t rr_pick;
  logic      any_req;
  port_idx_t sel;

  // --------------------
  // Round-robin pick
  // --------------------
  always_comb begin
    int unsigned cand;
    rr_pick = last_q;
    any_req = 1'b0;
    // Walk from the far end so the nearest port after the last winner is kept
    for (int unsigned k = NUM_PORTS; k > 0; k--) begin
      cand = (32'(last_q) + k) % NUM_PORTS;
      if (req_valid_i[cand]) begin
        rr_pick = port_idx_t'(cand);
        any_req = 1'b1;
      end
    end
  end

  assign sel = lock_q ? sel_q : rr_pick;

  // --------------------
  // Grant outputs
  // --------------------
  assign grant.valid = lock_q ? req_valid_i[sel_q] : any_req;
  assign grant.port  = sel;
  assign grant.chan  = '{id: {sel, req_chan_i[sel].id}, addr: req_chan_i[sel].addr};

  // Only the winner sees the handshake
  always_comb begin
    req_ready_o      = '0;
    req_ready_o[sel] = grant.valid & grant.ready;
  end

  // --------------------
  // Lock and pointer state
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
      sel_q  <= '0;
      last_q <= port_idx_t'(NUM_PORTS - 1);  // Port 0 goes first
    end else if (grant.valid && grant.ready) begin
      lock_q <= 1'b0;
      last_q <= sel;
    end else if (grant.valid) begin
      lock_q <= 1'b1;                        // Stalled, keep this choice
      sel_q  <= sel;
    end
  end

endmodule

`default_nettype wire

//--- hdl/axi_mux_top.sv
// AXI mux top level
// Merges the upstream ports onto one downstream port
`timescale 1ns/100ps
`default_nettype none

module axi_mux_top
  import mux_cfg_pkg::*;
  import mux_chan_pkg::*;
#(
  parameter int unsigned MaxWTrans = MAX_W_TRANS
) (
  input  wire logic                      clk_i,
  input  wire logic                      arst_n_i,
  // Upstream AW
  input  wire logic      [NUM_PORTS-1:0] aw_valid_i,
  input  wire up_id_t    [NUM_PORTS-1:0] aw_id_i,
  input  wire addr_t     [NUM_PORTS-1:0] aw_addr_i,
  output logic           [NUM_PORTS-1:0] aw_ready_o,
  // Upstream W
  input  wire logic      [NUM_PORTS-1:0] w_valid_i,
  input  wire data_t     [NUM_PORTS-1:0] w_data_i,
  input  wire logic      [NUM_PORTS-1:0] w_last_i,
  output logic           [NUM_PORTS-1:0] w_ready_o,
  // Upstream B
  output logic           [NUM_PORTS-1:0] b_valid_o,
  output up_id_t         [NUM_PORTS-1:0] b_id_o,
  output logic [NUM_PORTS-1:0][1:0]      b_resp_o,
  input  wire logic      [NUM_PORTS-1:0] b_ready_i,
  // Upstream AR
  input  wire logic      [NUM_PORTS-1:0] ar_valid_i,
  input  wire up_id_t    [NUM_PORTS-1:0] ar_id_i,
  input  wire addr_t     [NUM_PORTS-1:0] ar_addr_i,
  output logic           [NUM_PORTS-1:0] ar_ready_o,
  // Upstream R
  output logic           [NUM_PORTS-1:0] r_valid_o,
  output up_id_t         [NUM_PORTS-1:0] r_id_o,
  output data_t          [NUM_PORTS-1:0] r_data_o,
  output logic [NUM_PORTS-1:0][1:0]      r_resp_o,
  output logic           [NUM_PORTS-1:0] r_last_o,
  input  wire logic      [NUM_PORTS-1:0] r_ready_i,
  // Downstream AW and W
  output logic                           m_aw_valid_o,
  input  wire logic                      m_aw_ready_i,
  output dn_id_t                         m_aw_id_o,
  output addr_t                          m_aw_addr_o,
  output logic                           m_w_valid_o,
  input  wire logic                      m_w_ready_i,
  output data_t                          m_w_data_o,
  output logic                           m_w_last_o,
  // Downstream B
  input  wire logic                      m_b_valid_i,
  output logic                           m_b_ready_o,
  input  wire dn_id_t                    m_b_id_i,
  input  wire logic [1:0]                m_b_resp_i,
  // Downstream AR
  output logic                           m_ar_valid_o,
  input  wire logic                      m_ar_ready_i,
  output dn_id_t                         m_ar_id_o,
  output addr_t                          m_ar_addr_o,
  // Downstream R
  input  wire logic                      m_r_valid_i,
  output logic                           m_r_ready_o,
  input  wire dn_id_t                    m_r_id_i,
  input  wire data_t                     m_r_data_i,
  input  wire logic [1:0]                m_r_resp_i,
  input  wire logic                      m_r_last_i
);

  localparam int unsigned RPayloadW = DATA_W + 3;  // data, resp, last

  up_addr_chan_t [NUM_PORTS-1:0] aw_chans, ar_chans;
  w_chan_t       [NUM_PORTS-1:0] w_chans;
  dn_addr_chan_t                 m_aw_chan;
  w_chan_t                       m_w_chan;
  dn_b_chan_t                    m_b_chan;
  dn_r_chan_t                    m_r_chan;
  up_id_t                        b_up_id, r_up_id;
  logic [1:0]                    b_up_resp;
  logic [RPayloadW-1:0]          r_up_payload;

  addr_chan_if aw_if ();
  addr_chan_if ar_if ();

  // --------------------
  // Port packing
  // --------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_pack
    assign aw_chans[p] = '{id: aw_id_i[p], addr: aw_addr_i[p]};
    assign ar_chans[p] = '{id: ar_id_i[p], addr: ar_addr_i[p]};
    assign w_chans[p]  = '{data: w_data_i[p], last: w_last_i[p]};
  end

  assign m_b_chan = '{id: m_b_id_i, resp: m_b_resp_i};
  assign m_r_chan = '{id: m_r_id_i, data: m_r_data_i, resp: m_r_resp_i, last: m_r_last_i};

  // --------------------
  // Write path
  // --------------------
  addr_rr_arbiter u_aw_arbiter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (aw_valid_i),
    .req_chan_i  (aw_chans),
    .req_ready_o (aw_ready_o),
    .grant       (aw_if.src)
  );

  write_order_ctrl #(
    .MaxWTrans (MaxWTrans)
  ) u_write_order_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .aw            (aw_if.dst),
    .dn_aw_valid_o (m_aw_valid_o),
    .dn_aw_ready_i (m_aw_ready_i),
    .dn_aw_chan_o  (m_aw_chan),
    .w_valid_i     (w_valid_i),
    .w_chan_i      (w_chans),
    .w_ready_o     (w_ready_o),
    .dn_w_valid_o  (m_w_valid_o),
    .dn_w_ready_i  (m_w_ready_i),
    .dn_w_chan_o   (m_w_chan)
  );

  assign m_aw_id_o   = m_aw_chan.id;
  assign m_aw_addr_o = m_aw_chan.addr;
  assign m_w_data_o  = m_w_chan.data;
  assign m_w_last_o  = m_w_chan.last;

  resp_router #(
    .PayloadW (2)
  ) u_b_router (
    .dn_valid_i   (m_b_valid_i),
    .dn_id_i      (m_b_chan.id),
    .dn_payload_i (m_b_chan.resp),
    .dn_ready_o   (m_b_ready_o),
    .up_valid_o   (b_valid_o),
    .up_id_o      (b_up_id),
    .up_payload_o (b_up_resp),
    .up_ready_i   (b_ready_i)
  );

  assign b_id_o   = {NUM_PORTS{b_up_id}};    // Same fields on every port
  assign b_resp_o = {NUM_PORTS{b_up_resp}};

  // --------------------
  // Read path
  // --------------------
  addr_rr_arbiter u_ar_arbiter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (ar_valid_i),
    .req_chan_i  (ar_chans),
    .req_ready_o (ar_ready_o),
    .grant       (ar_if.src)
  );

  // AR goes straight out, no ordering needed
  assign m_ar_valid_o = ar_if.valid;
  assign ar_if.ready  = m_ar_ready_i;
  assign m_ar_id_o    = ar_if.chan.id;
  assign m_ar_addr_o  = ar_if.chan.addr;

  resp_router #(
    .PayloadW (RPayloadW)
  ) u_r_router (
    .dn_valid_i   (m_r_valid_i),
    .dn_id_i      (m_r_chan.id),
    .dn_payload_i ({m_r_chan.data, m_r_chan.resp, m_r_chan.last}),
    .dn_ready_o   (m_r_ready_o),
    .up_valid_o   (r_valid_o),
    .up_id_o      (r_up_id),
    .up_payload_o (r_up_payload),
    .up_ready_i   (r_ready_i)
  );

  assign r_id_o   = {NUM_PORTS{r_up_id}};
  assign r_data_o = {NUM_PORTS{r_up_payload[RPayloadW-1 -: DATA_W]}};
  assign r_resp_o = {NUM_PORTS{r_up_payload[2:1]}};
  assign r_last_o = {NUM_PORTS{r_up_payload[0]}};

endmodule

`default_nettype wire

//--- hdl/mux_cfg_pkg.sv
// Mux configuration
// Port count, field widths and FIFO depth shared by every block of the mux
`default_nettype none

package mux_cfg_pkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int unsigned NUM_PORTS   = 3;                     // Upstream ports
  localparam int unsigned PORT_IDX_W  = $clog2(NUM_PORTS);     // Bits for a port index
  localparam int unsigned UP_ID_W     = 4;                     // Upstream ID width
  localparam int unsigned DN_ID_W     = PORT_IDX_W + UP_ID_W;  // Index prepended to ID
  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned MAX_W_TRANS = 4;                     // Default W routing depth

  // --------------------
  // Scalar types
  // --------------------
  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [UP_ID_W-1:0]    up_id_t;
  typedef logic [DN_ID_W-1:0]    dn_id_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;

endpackage

`default_nettype wire

//--- hdl/mux_chan_pkg.sv
// Mux channel payloads
// Packed structs for the AXI channel fields kept on both sides of the mux
`default_nettype none

package mux_chan_pkg;

  import mux_cfg_pkg::*;

  // --------------------
  // Address channels
  // --------------------
  // Shared by AW and AR
  typedef struct packed {
    up_id_t id;
    addr_t  addr;
  } up_addr_chan_t;

  typedef struct packed {
    dn_id_t id;    // Port index in the top bits
    addr_t  addr;
  } dn_addr_chan_t;

  // --------------------
  // Write data
  // --------------------
  typedef struct packed {
    data_t data;
    logic  last;   // Final beat of a burst
  } w_chan_t;

  // --------------------
  // Responses
  // --------------------
  typedef struct packed {
    dn_id_t     id;
    logic [1:0] resp;
  } dn_b_chan_t;

  typedef struct packed {
    dn_id_t     id;
    data_t      data;
    logic [1:0] resp;
    logic       last;
  } dn_r_chan_t;

endpackage

`default_nettype wire

//--- hdl/resp_router.sv
// Response router
// Sends a downstream B or R beat to the port named by its top ID bits
`timescale 1ns/100ps
`default_nettype none

module resp_router
  import mux_cfg_pkg::*;
#(
  parameter int unsigned PayloadW = 2  // Response fields other than the ID
) (
  // Downstream side
  input  wire logic                 dn_valid_i,
  input  wire dn_id_t               dn_id_i,
  input  wire logic [PayloadW-1:0]  dn_payload_i,
  output logic                      dn_ready_o,
  // Upstream side, payload shared by all ports
  output logic      [NUM_PORTS-1:0] up_valid_o,
  output up_id_t                    up_id_o,
  output logic      [PayloadW-1:0]  up_payload_o,
  input  wire logic [NUM_PORTS-1:0] up_ready_i
);

  port_idx_t dst_port;
  logic      dst_legal;

  // --------------------
  // ID split
  // --------------------
  assign dst_port     = dn_id_i[DN_ID_W-1 -: PORT_IDX_W];  // Prepended index
  assign dst_legal    = (32'(dst_port) < NUM_PORTS);
  assign up_id_o      = dn_id_i[UP_ID_W-1:0];              // Original upstream ID
  assign up_payload_o = dn_payload_i;

  // --------------------
  // Handshake steering
  // --------------------
  always_comb begin
    up_valid_o = '0;
    dn_ready_o = 1'b0;
    // An index with no port behind it is never acknowledged
    if (dst_legal) begin
      up_valid_o[dst_port] = dn_valid_i;
      dn_ready_o           = up_ready_i[dst_port];
    end
  end

endmodule

`default_nettype wire

//--- hdl/write_order_ctrl.sv
// Write ordering control
// Issues granted AW requests downstream, records their port in a routing FIFO
// and forwards W beats in that order
`timescale 1ns/100ps
`default_nettype none

module write_order_ctrl
  import mux_cfg_pkg::*;
  import mux_chan_pkg::*;
#(
  parameter int unsigned MaxWTrans = MAX_W_TRANS  // Routing FIFO depth
) (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  addr_chan_if.dst                     aw,
  // Downstream AW
  output logic                         dn_aw_valid_o,
  input  wire logic                    dn_aw_ready_i,
  output dn_addr_chan_t                dn_aw_chan_o,
  // Upstream W
  input  wire logic    [NUM_PORTS-1:0] w_valid_i,
  input  wire w_chan_t [NUM_PORTS-1:0] w_chan_i,
  output logic         [NUM_PORTS-1:0] w_ready_o,
  // Downstream W
  output logic                         dn_w_valid_o,
  input  wire logic                    dn_w_ready_i,
  output w_chan_t                      dn_w_chan_o
);

  localparam int unsigned PtrW = $clog2(MaxWTrans);
  localparam int unsigned CntW = $clog2(MaxWTrans + 1);

  logic            lock_q, lock_d;  // AW offered and index already pushed
  logic            fifo_push, fifo_pop;
  logic            fifo_full, fifo_empty;
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  port_idx_t       fifo_mem [MaxWTrans];
  port_idx_t       head;

  // --------------------
  // AW issue
  // --------------------
  assign dn_aw_chan_o = aw.chan;

  always_comb begin
    lock_d        = lock_q;
    fifo_push     = 1'b0;
    dn_aw_valid_o = 1'b0;
    aw.ready      = 1'b0;
    if (lock_q) begin
      // Index is already queued, just hold valid until accepted
      dn_aw_valid_o = 1'b1;
      if (dn_aw_ready_i) begin
        aw.ready = 1'b1;
        lock_d   = 1'b0;
      end
    end else if (aw.valid && !fifo_full) begin
      dn_aw_valid_o = 1'b1;
      fifo_push     = 1'b1;  // Push on the offer edge
      if (dn_aw_ready_i) begin
        aw.ready = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  // --------------------
  // W routing
  // --------------------
  assign head        = fifo_mem[rd_ptr_q];
  assign dn_w_chan_o = w_chan_i[head];

  always_comb begin
    dn_w_valid_o = 1'b0;
    w_ready_o    = '0;
    if (!fifo_empty) begin
      dn_w_valid_o    = w_valid_i[head];
      w_ready_o[head] = dn_w_ready_i;
    end
  end

  assign fifo_pop = dn_w_valid_o & dn_w_ready_i & dn_w_chan_o.last;  // Burst done

  // --------------------
  // Routing FIFO
  // --------------------
  assign fifo_full  = (count_q == CntW'(MaxWTrans));
  assign fifo_empty = (count_q == '0);

  always_ff @(posedge clk_i) begin
    if (fifo_push) begin
      fifo_mem[wr_ptr_q] <= aw.port;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q   <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      lock_q <= lock_d;
      if (fifo_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(MaxWTrans - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(MaxWTrans - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({fifo_push, fifo_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;         // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI mux simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_axi_mux \
  -f src.f \
  -o sim_axi_mux
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_axi_mux > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "Everything OK" sim.log; then
  exit 0
else
  exit 1
fi

//--- src.f
hdl/mux_cfg_pkg.sv
hdl/mux_chan_pkg.sv
hdl/addr_chan_if.sv
hdl/addr_rr_arbiter.sv
hdl/write_order_ctrl.sv
hdl/resp_router.sv
hdl/axi_mux_top.sv
tests/axi_mux_props.sv
tests/tb_axi_mux.sv

//--- tests/axi_mux_props.sv
// Handshake properties of the mux
// Reset values and stability of the downstream requests
`timescale 1ns/100ps
`default_nettype none

module axi_mux_props
  import mux_cfg_pkg::*;
(
  input wire logic   clk_i,
  input wire logic   arst_n_i,
  input wire logic   m_aw_valid_o,
  input wire logic   m_aw_ready_i,
  input wire dn_id_t m_aw_id_o,
  input wire addr_t  m_aw_addr_o,
  input wire logic   m_w_valid_o,
  input wire logic   m_w_ready_i,
  input wire data_t  m_w_data_o,
  input wire logic   m_w_last_o,
  input wire logic   m_ar_valid_o,
  input wire logic   m_ar_ready_i,
  input wire dn_id_t m_ar_id_o,
  input wire addr_t  m_ar_addr_o
);

  reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> !m_aw_valid_o && !m_w_valid_o && !m_ar_valid_o)
    else $error("downstream valid high during reset");

  aw_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_aw_valid_o && !m_aw_ready_i |=>
      m_aw_valid_o && $stable(m_aw_id_o) && $stable(m_aw_addr_o))
    else $error("AW dropped or changed before acceptance");

  w_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_w_valid_o && !m_w_ready_i |=>
      m_w_valid_o && $stable(m_w_data_o) && $stable(m_w_last_o))
    else $error("W dropped or changed before acceptance");

  ar_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_ar_valid_o && !m_ar_ready_i |=>
      m_ar_valid_o && $stable(m_ar_id_o) && $stable(m_ar_addr_o))
    else $error("AR dropped or changed before acceptance");

endmodule

bind axi_mux_top axi_mux_props u_props (
  .clk_i (clk_i), .arst_n_i (arst_n_i),
  .m_aw_valid_o (m_aw_valid_o), .m_aw_ready_i (m_aw_ready_i),
  .m_aw_id_o (m_aw_id_o), .m_aw_addr_o (m_aw_addr_o),
  .m_w_valid_o (m_w_valid_o), .m_w_ready_i (m_w_ready_i),
  .m_w_data_o (m_w_data_o), .m_w_last_o (m_w_last_o),
  .m_ar_valid_o (m_ar_valid_o), .m_ar_ready_i (m_ar_ready_i),
  .m_ar_id_o (m_ar_id_o), .m_ar_addr_o (m_ar_addr_o)
);

`default_nettype wire

//--- tests/tb_axi_mux.sv
// AXI mux testbench
// Random upstream traffic and a downstream responder, checked against a model
`timescale 1ns/100ps
`default_nettype none

module tb_axi_mux
  import mux_cfg_pkg::*;
();

  localparam int unsigned NumTxn        = 40;                // Per address channel
  localparam int unsigned MaxW          = 4;                 // Routing FIFO depth
  localparam int unsigned TimeoutCycles = 2 * NumTxn * 40;

  logic clk, arst_n;
  logic [NUM_PORTS-1:0] aw_valid, aw_ready, w_valid, w_ready, w_last;
  logic [NUM_PORTS-1:0] b_valid, b_ready, ar_valid, ar_ready, r_valid, r_ready, r_last;
  up_id_t [NUM_PORTS-1:0] aw_id, ar_id, b_id, r_id;
  addr_t  [NUM_PORTS-1:0] aw_addr, ar_addr;
  data_t  [NUM_PORTS-1:0] w_data, r_data;
  logic [NUM_PORTS-1:0][1:0] b_resp, r_resp;
  logic   m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_w_last, m_b_valid, m_b_ready;
  logic   m_ar_valid, m_ar_ready, m_r_valid, m_r_ready, m_r_last;
  dn_id_t m_aw_id, m_ar_id, m_b_id, m_r_id;
  addr_t  m_aw_addr, m_ar_addr;
  data_t  m_w_data, m_r_data;
  logic [1:0] m_b_resp, m_r_resp;

  // --------------------
  // Model state
  // --------------------
  logic [31:0]       lcg_state;
  int                err_cnt, chk_cnt, out_cnt, aw_issued, ar_issued;
  up_id_t            exp_aw_id [NUM_PORTS];
  addr_t             exp_aw_addr [NUM_PORTS];
  up_id_t            exp_ar_id [NUM_PORTS];
  addr_t             exp_ar_addr [NUM_PORTS];
  int                aw_wait [NUM_PORTS];    // Grants to others while requesting
  int                ar_wait [NUM_PORTS];
  logic [NUM_PORTS-1:0] aw_done, w_done, ar_done;
  logic              b_done, r_done;
  logic [DATA_W:0]   wbeat_q [NUM_PORTS][$];  // Beats still to send per port
  logic [DATA_W:0]   exp_w [$];               // Downstream W in AW order
  dn_id_t            aw_order [$];            // Bursts waiting for their last beat
  dn_id_t            b_pend [$];
  logic [DN_ID_W:0]  r_pend [$];              // ID and last flag per R beat

  axi_mux_top #(
    .MaxWTrans (MaxW)
  ) u_axi_mux_top (
    .clk_i (clk), .arst_n_i (arst_n),
    .aw_valid_i (aw_valid), .aw_id_i (aw_id), .aw_addr_i (aw_addr), .aw_ready_o (aw_ready),
    .w_valid_i (w_valid), .w_data_i (w_data), .w_last_i (w_last), .w_ready_o (w_ready),
    .b_valid_o (b_valid), .b_id_o (b_id), .b_resp_o (b_resp), .b_ready_i (b_ready),
    .ar_valid_i (ar_valid), .ar_id_i (ar_id), .ar_addr_i (ar_addr), .ar_ready_o (ar_ready),
    .r_valid_o (r_valid), .r_id_o (r_id), .r_data_o (r_data), .r_resp_o (r_resp),
    .r_last_o (r_last), .r_ready_i (r_ready),
    .m_aw_valid_o (m_aw_valid), .m_aw_ready_i (m_aw_ready), .m_aw_id_o (m_aw_id),
    .m_aw_addr_o (m_aw_addr), .m_w_valid_o (m_w_valid), .m_w_ready_i (m_w_ready),
    .m_w_data_o (m_w_data), .m_w_last_o (m_w_last),
    .m_b_valid_i (m_b_valid), .m_b_ready_o (m_b_ready), .m_b_id_i (m_b_id),
    .m_b_resp_i (m_b_resp),
    .m_ar_valid_o (m_ar_valid), .m_ar_ready_i (m_ar_ready), .m_ar_id_o (m_ar_id),
    .m_ar_addr_o (m_ar_addr),
    .m_r_valid_i (m_r_valid), .m_r_ready_o (m_r_ready), .m_r_id_i (m_r_id),
    .m_r_data_i (m_r_data), .m_r_resp_i (m_r_resp), .m_r_last_i (m_r_last)
  );

  always #50 clk = ~clk;

  function automatic int unsigned lcg();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'b0, lcg_state[30:16]};
  endfunction

  function automatic logic [31:0] rnd32();
    logic [15:0] hi, lo;
    hi = 16'(lcg());
    lo = 16'(lcg());
    return {hi, lo};
  endfunction

  task automatic compare_value(input logic ok, input string msg);
    chk_cnt++;
    assert (ok) else begin
      $display("mismatch at %0t: %s", $time, msg);
      err_cnt++;
    end
  endtask

  task automatic require_rule(input logic ok, input string msg);
    chk_cnt++;
    assert (ok) else begin
      $display("error at %0t: %s", $time, msg);
      err_cnt++;
    end
  endtask

  // --------------------
  // Monitor on the falling edge where everything is settled
  // --------------------
  task automatic observe();
    port_idx_t        p;
    logic [DATA_W:0]  beat;
    int unsigned      len;
    aw_done = '0;
    w_done  = '0;
    ar_done = '0;
    b_done  = 1'b0;
    r_done  = 1'b0;
    if (m_aw_valid && m_aw_ready) begin
      p = m_aw_id[DN_ID_W-1 -: PORT_IDX_W];
      require_rule(out_cnt < MaxW, "AW accepted with the write FIFO full");
      require_rule(aw_valid[p] && aw_ready[p], "AW issued without upstream handshake");
      compare_value(m_aw_id[UP_ID_W-1:0] == exp_aw_id[p] && m_aw_addr == exp_aw_addr[p],
                    $sformatf("AW port %0d id %h addr %h", p, m_aw_id, m_aw_addr));
    end
    for (int q = 0; q < NUM_PORTS; q++) begin
      if (aw_valid[q] && aw_ready[q]) begin
        aw_done[q] = 1'b1;
        aw_wait[q] = 0;
        out_cnt++;
        aw_order.push_back({port_idx_t'(q), exp_aw_id[q]});
        len = 1 + lcg() % 4;
        for (int unsigned b = 0; b < len; b++) begin
          beat = {rnd32(), b == len - 1};
          wbeat_q[q].push_back(beat);
          exp_w.push_back(beat);
        end
      end else if (aw_valid[q] && |(aw_valid & aw_ready)) begin
        aw_wait[q]++;
        require_rule(aw_wait[q] <= NUM_PORTS, $sformatf("AW port %0d starved", q));
      end
      if (w_valid[q] && w_ready[q]) begin
        w_done[q] = 1'b1;
        void'(wbeat_q[q].pop_front());
      end
    end
    // Downstream W must follow AW acceptance order
    if (m_w_valid && m_w_ready) begin
      require_rule(exp_w.size() > 0, "W beat with no burst expected");
      if (exp_w.size() > 0) begin
        p = aw_order[0][DN_ID_W-1 -: PORT_IDX_W];
        compare_value((w_valid & w_ready) == (NUM_PORTS'(1) << p),
                      $sformatf("W handshake %b, expected port %0d", w_valid & w_ready, p));
        beat = exp_w.pop_front();
        compare_value({m_w_data, m_w_last} == beat,
                      $sformatf("W data %h last %b, expected %h", m_w_data, m_w_last, beat));
        if (beat[0]) begin
          out_cnt--;
          b_pend.push_back(aw_order.pop_front());
        end
      end
    end else begin
      compare_value((w_valid & w_ready) == '0, "W upstream handshake with none downstream");
    end
    if (m_ar_valid && m_ar_ready) begin
      p = m_ar_id[DN_ID_W-1 -: PORT_IDX_W];
      require_rule(ar_valid[p] && ar_ready[p], "AR issued without upstream handshake");
      compare_value(m_ar_id[UP_ID_W-1:0] == exp_ar_id[p] && m_ar_addr == exp_ar_addr[p],
                    $sformatf("AR port %0d id %h addr %h", p, m_ar_id, m_ar_addr));
      len = 1 + lcg() % 2;
      for (int unsigned b = 0; b < len; b++) begin
        r_pend.push_back({m_ar_id, b == len - 1});
      end
    end
    for (int q = 0; q < NUM_PORTS; q++) begin
      if (ar_valid[q] && ar_ready[q]) begin
        ar_done[q] = 1'b1;
        ar_wait[q] = 0;
      end else if (ar_valid[q] && |(ar_valid & ar_ready)) begin
        ar_wait[q]++;
        require_rule(ar_wait[q] <= NUM_PORTS, $sformatf("AR port %0d starved", q));
      end
    end
    // Responses go to exactly one port
    if (m_b_valid) begin
      p = m_b_id[DN_ID_W-1 -: PORT_IDX_W];
      compare_value(b_valid == (NUM_PORTS'(1) << p) && b_id[p] == m_b_id[UP_ID_W-1:0]
                    && b_resp[p] == m_b_resp && m_b_ready == b_ready[p],
                    $sformatf("B id %h routed as valid %b", m_b_id, b_valid));
      b_done = m_b_ready;
    end else begin
      compare_value(b_valid == '0, "B valid upstream with none downstream");
    end
    if (m_r_valid) begin
      p = m_r_id[DN_ID_W-1 -: PORT_IDX_W];
      compare_value(r_valid == (NUM_PORTS'(1) << p) && r_id[p] == m_r_id[UP_ID_W-1:0]
                    && r_data[p] == m_r_data && r_resp[p] == m_r_resp
                    && r_last[p] == m_r_last && m_r_ready == r_ready[p],
                    $sformatf("R id %h routed as valid %b", m_r_id, r_valid));
      r_done = m_r_ready;
    end else begin
      compare_value(r_valid == '0, "R valid upstream with none downstream");
    end
    if (b_done) void'(b_pend.pop_front());
    if (r_done) void'(r_pend.pop_front());
  endtask

  // --------------------
  // Stimulus just after the rising edge
  // --------------------
  task automatic drive();
    for (int q = 0; q < NUM_PORTS; q++) begin
      if (aw_done[q]) aw_valid[q] = 1'b0;
      if (!aw_valid[q] && aw_issued < NumTxn && lcg() % 3 == 0) begin
        aw_valid[q]    = 1'b1;
        aw_id[q]       = up_id_t'(lcg());
        aw_addr[q]     = rnd32();
        exp_aw_id[q]   = aw_id[q];
        exp_aw_addr[q] = aw_addr[q];
        aw_issued++;
      end
      if (w_done[q]) w_valid[q] = 1'b0;
      if (!w_valid[q] && wbeat_q[q].size() > 0 && lcg() % 4 != 0) begin
        w_valid[q]              = 1'b1;
        {w_data[q], w_last[q]}  = wbeat_q[q][0];
      end
      if (ar_done[q]) ar_valid[q] = 1'b0;
      if (!ar_valid[q] && ar_issued < NumTxn && lcg() % 3 == 0) begin
        ar_valid[q]    = 1'b1;
        ar_id[q]       = up_id_t'(lcg());
        ar_addr[q]     = rnd32();
        exp_ar_id[q]   = ar_id[q];
        exp_ar_addr[q] = ar_addr[q];
        ar_issued++;
      end
      b_ready[q] = (lcg() % 4 != 0);
      r_ready[q] = (lcg() % 4 != 0);
    end
    m_aw_ready = (lcg() % 4 != 0);
    m_w_ready  = (lcg() % 3 != 0);  // Slower W lets the FIFO fill
    m_ar_ready = (lcg() % 4 != 0);
    if (b_done) m_b_valid = 1'b0;
    if (!m_b_valid && b_pend.size() > 0 && lcg() % 2 == 0) begin
      m_b_valid = 1'b1;
      m_b_id    = b_pend[0];
      m_b_resp  = 2'(lcg());
    end
    if (r_done) m_r_valid = 1'b0;
    if (!m_r_valid && r_pend.size() > 0 && lcg() % 2 == 0) begin
      m_r_valid         = 1'b1;
      {m_r_id, m_r_last} = r_pend[0];
      m_r_data          = rnd32();
      m_r_resp          = 2'(lcg());
    end
  endtask

  function automatic logic drained();
    return aw_issued >= NumTxn && ar_issued >= NumTxn && aw_valid == '0
           && w_valid == '0 && ar_valid == '0 && !m_b_valid && !m_r_valid
           && exp_w.size() == 0 && b_pend.size() == 0 && r_pend.size() == 0;
  endfunction

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    lcg_state  = 32'd7;
    aw_valid   = '0;
    aw_id      = '0;
    aw_addr    = '0;
    w_valid    = '0;
    w_data     = '0;
    w_last     = '0;
    b_ready    = '0;
    ar_valid   = '0;
    ar_id      = '0;
    ar_addr    = '0;
    r_ready    = '0;
    m_aw_ready = 1'b0;
    m_w_ready  = 1'b0;
    m_ar_ready = 1'b0;
    m_b_valid  = 1'b0;
    m_b_id     = '0;
    m_b_resp   = '0;
    m_r_valid  = 1'b0;
    m_r_id     = '0;
    m_r_data   = '0;
    m_r_resp   = '0;
    m_r_last   = 1'b0;
    err_cnt    = 0;
    chk_cnt    = 0;
    out_cnt    = 0;
    aw_issued  = 0;
    ar_issued  = 0;
    aw_done    = '0;
    w_done     = '0;
    ar_done    = '0;
    b_done     = 1'b0;
    r_done     = 1'b0;
    for (int q = 0; q < NUM_PORTS; q++) begin
      aw_wait[q] = 0;
      ar_wait[q] = 0;
    end
    repeat (3) @(posedge clk);
    #10 arst_n = 1'b1;
    while (!drained()) begin
      @(negedge clk);
      observe();
      @(posedge clk);
      #10;
      drive();
    end
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("timeout: traffic did not drain within %0d cycles", TimeoutCycles);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
